/* Bender.yml */
package:
  name: decode_stage

sources:
  - logic/decode_pkg.sv
  - logic/decoded_inst_if.sv
  - logic/inst_decoder.sv
  - logic/hazard_check.sv
  - logic/register_file.sv
  - logic/decode_stage.sv
  - logic/decode_top.sv
  - target: simulation
    files:
      - bench/decode_checker.sv
      - bench/decode_tb.sv

/* bench/decode_checker.sv */
`default_nettype none

module decode_checker (
	input logic                                  clock,
	input logic                                  rst_n,
	input logic                                  in_valid,
	input logic                                  in_ready,
	input decode_pkg::word_t                     inst,
	input decode_pkg::word_t                     pc,
	input logic                                  out_valid,
	input logic                                  out_ready,
	input logic [decode_pkg::OP_CLASS_COUNT-1:0] op_class,
	input logic [2:0]                            funct3,
	input logic [6:0]                            funct7,
	input decode_pkg::reg_addr_t                 rd,
	input decode_pkg::word_t                     imm,
	input decode_pkg::word_t                     pc_out,
	input decode_pkg::word_t                     src1_out,
	input decode_pkg::word_t                     src2_out,
	input logic                                  reg_wen,
	input logic                                  is_fencei,
	input logic                                  is_ecall,
	input logic                                  is_mret,
	input decode_pkg::reg_addr_t                 exu_rd,
	input logic                                  exu_reg_wen,
	input logic                                  exu_ready,
	input decode_pkg::reg_addr_t                 lsu_rd,
	input logic                                  lsu_reg_wen,
	input logic                                  lsu_ready,
	input logic                                  jump_wrong,
	input logic                                  wb_en,
	input decode_pkg::reg_addr_t                 wb_rd,
	input decode_pkg::word_t                     wb_data
);
	timeunit 1ns;
	timeprecision 100ps;

	int pass_count = 0;
	int fail_count = 0;
	int test_errors = 0;
	int test_num = 0;
	decode_pkg::word_t shadow [decode_pkg::NUM_REGS]; // Register file model
	logic exp_empty;
	logic exp_valid;
	decode_pkg::word_t held_inst; // Instruction in the output register
	decode_pkg::word_t exp_pc;
	decode_pkg::word_t exp_src1;
	decode_pkg::word_t exp_src2;

	function automatic logic [9:0] class_of(decode_pkg::word_t w);
		logic [9:0] c;
		c = '0;
		case (w[6:0])
			decode_pkg::OPC_LUI:     c[0] = 1'b1;
			decode_pkg::OPC_AUIPC:   c[1] = 1'b1;
			decode_pkg::OPC_JAL:     c[2] = 1'b1;
			decode_pkg::OPC_JALR:    c[3] = 1'b1;
			decode_pkg::OPC_BRANCH:  c[4] = 1'b1;
			decode_pkg::OPC_LOAD:    c[5] = 1'b1;
			decode_pkg::OPC_STORE:   c[6] = 1'b1;
			decode_pkg::OPC_ALU_IMM: c[7] = 1'b1;
			decode_pkg::OPC_ALU_REG: c[8] = 1'b1;
			decode_pkg::OPC_SYSTEM:  c[9] = 1'b1;
			default:                 c = '0;
		endcase
		return c;
	endfunction

	function automatic decode_pkg::word_t imm_of(decode_pkg::word_t w);
		case (w[6:0])
			decode_pkg::OPC_JALR, decode_pkg::OPC_LOAD, decode_pkg::OPC_ALU_IMM,
			decode_pkg::OPC_SYSTEM: return {{20{w[31]}}, w[31:20]};
			decode_pkg::OPC_LUI, decode_pkg::OPC_AUIPC: return {w[31:12], 12'h000};
			decode_pkg::OPC_STORE: return {{20{w[31]}}, w[31:25], w[11:7]};
			decode_pkg::OPC_JAL: return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			decode_pkg::OPC_BRANCH: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
			default: return '0;
		endcase
	endfunction

	function automatic logic wen_of(decode_pkg::word_t w);
		case (w[6:0])
			decode_pkg::OPC_ALU_REG, decode_pkg::OPC_LUI, decode_pkg::OPC_AUIPC,
			decode_pkg::OPC_JAL, decode_pkg::OPC_JALR, decode_pkg::OPC_LOAD,
			decode_pkg::OPC_ALU_IMM: return 1'b1;
			decode_pkg::OPC_SYSTEM: return w[14:12] != 3'b000;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic owes(decode_pkg::word_t w, decode_pkg::reg_addr_t r, logic wen,
		logic rdy);
		logic uses_rs2;
		uses_rs2 = (w[6:0] == decode_pkg::OPC_BRANCH) || (w[6:0] == decode_pkg::OPC_STORE)
			|| (w[6:0] == decode_pkg::OPC_ALU_REG);
		return !rdy && wen && r != 0 && (r == w[18:15] || (uses_rs2 && r == w[23:20]));
	endfunction

	function automatic logic ready_model();
		return exp_empty && !owes(inst, exu_rd, exu_reg_wen, exu_ready)
			&& !owes(inst, lsu_rd, lsu_reg_wen, lsu_ready);
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic note_failure(input string msg);
		$display("test %0d: %s", test_num, msg);
		test_errors++;
	endtask

	task automatic end_test();
		#1; // Past the checks of this clock edge
		if (test_errors == 0) begin
			pass_count++;
			$display("test %0d passed", test_num);
		end else begin
			fail_count++;
			$display("test %0d failed with %0d errors", test_num, test_errors);
		end
		test_errors = 0;
		test_num++;
	endtask

	task automatic report();
		$display("%0d tests passed, %0d tests failed", pass_count, fail_count);
	endtask

	always @(posedge clock) begin
		if (!rst_n) begin
			exp_empty = 1'b1;
			exp_valid = 1'b0;
			for (int i = 0; i < decode_pkg::NUM_REGS; i++) begin
				shadow[i] = '0;
			end
		end else begin
			if (jump_wrong) begin
				exp_empty = 1'b1;
				exp_valid = 1'b0;
			end else if (in_valid && ready_model()) begin
				held_inst = inst;
				exp_pc = pc;
				exp_src1 = shadow[inst[18:15]]; // Old value on a same-cycle write
				exp_src2 = shadow[inst[23:20]];
				exp_empty = 1'b0;
				exp_valid = 1'b1;
			end else if (exp_valid && out_ready) begin
				exp_empty = 1'b1;
				exp_valid = 1'b0;
			end
			if (wb_en && wb_rd != 0) shadow[wb_rd] = wb_data;
		end
	end

	always @(negedge clock) begin
		if (rst_n) begin
			check("in_ready", in_ready, ready_model());
			check("out_valid", out_valid, exp_valid);
			if (exp_valid) begin
				check("op_class", op_class, class_of(held_inst));
				check("funct3", funct3, held_inst[14:12]);
				check("funct7", funct7, held_inst[31:25]);
				check("rd", rd, held_inst[10:7]);
				check("imm", imm, imm_of(held_inst));
				check("pc_out", pc_out, exp_pc);
				check("src1_out", src1_out, exp_src1);
				check("src2_out", src2_out, exp_src2);
				check("reg_wen", reg_wen, wen_of(held_inst));
				check("is_fencei", is_fencei, held_inst[6:0] == decode_pkg::OPC_MISC_MEM);
				check("is_ecall", is_ecall, held_inst == decode_pkg::INST_ECALL);
				check("is_mret", is_mret, held_inst == decode_pkg::INST_MRET);
			end
		end
	end

endmodule

`default_nettype wire

/* bench/decode_tb.sv */
`default_nettype none

module decode_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_ROWS = 22;

	// Hazard source is 0 for none, 1 for a busy execute stage, 2 for a busy load/store stage
	typedef struct {
		decode_pkg::word_t inst;
		decode_pkg::word_t pc;
		int hz;
		decode_pkg::reg_addr_t hz_rd;
		int busy;
		int hold;
		bit flush;
		bit stall;
	} row_t;

	logic clock, rst_n, in_valid, in_ready, out_valid, out_ready;
	decode_pkg::word_t inst, pc, imm, pc_out, src1_out, src2_out, wb_data;
	logic [decode_pkg::OP_CLASS_COUNT-1:0] op_class;
	logic [2:0] funct3;
	logic [6:0] funct7;
	decode_pkg::reg_addr_t rd, exu_rd, lsu_rd, wb_rd;
	logic reg_wen, is_fencei, is_ecall, is_mret;
	logic exu_reg_wen, exu_ready, lsu_reg_wen, lsu_ready, jump_wrong, wb_en;
	logic [31:0] lfsr = 32'hf93f24cb;
	row_t rows [NUM_ROWS];

	decode_top u_decode_top (.*);
	decode_checker u_checker (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic decode_pkg::word_t enc_r(input logic [3:0] rs2, rs1, rdx);
		return {7'h00, 1'b0, rs2, 1'b0, rs1, 3'b000, 1'b0, rdx, decode_pkg::OPC_ALU_REG};
	endfunction

	function automatic decode_pkg::word_t enc_i(input logic [11:0] im, input logic [3:0] rs1,
		input logic [3:0] rdx, input logic [6:0] opc);
		return {im, 1'b0, rs1, 3'b010, 1'b0, rdx, opc};
	endfunction

	function automatic row_t mk(input decode_pkg::word_t w, input int hz, input int hz_rd,
		input int busy, input int hold, input bit flush, input bit stall);
		row_t r;
		r.inst = w;
		r.pc = {30'(rand_bits(30)), 2'b00};
		r.hz = hz;
		r.hz_rd = hz_rd[3:0];
		r.busy = busy;
		r.hold = hold;
		r.flush = flush;
		r.stall = stall;
		return r;
	endfunction

	task automatic build_table();
		rows[0] = mk({25'(rand_bits(25)), decode_pkg::OPC_LUI}, 0, 0, 0, 0, 0, 0);
		rows[1] = mk({25'(rand_bits(25)), decode_pkg::OPC_AUIPC}, 0, 0, 0, 2, 0, 0);
		rows[2] = mk({25'(rand_bits(25)), decode_pkg::OPC_JAL}, 0, 0, 0, 0, 0, 0);
		rows[3] = mk({25'(rand_bits(25)), decode_pkg::OPC_JALR}, 0, 0, 0, 0, 1, 0);
		rows[4] = mk({25'(rand_bits(25)), decode_pkg::OPC_BRANCH}, 0, 0, 0, 0, 0, 0);
		rows[5] = mk({25'(rand_bits(25)), decode_pkg::OPC_LOAD}, 0, 0, 0, 3, 0, 0);
		rows[6] = mk({25'(rand_bits(25)), decode_pkg::OPC_STORE}, 0, 0, 0, 0, 0, 0);
		rows[7] = mk({25'(rand_bits(25)), decode_pkg::OPC_ALU_IMM}, 0, 0, 0, 0, 0, 0);
		rows[8] = mk(enc_r(4'd2, 4'd1, 4'd13), 0, 0, 0, 1, 0, 0);
		rows[9] = mk({17'(rand_bits(17)), 3'b001, 5'd4, decode_pkg::OPC_SYSTEM}, 0, 0, 0, 0, 0, 0);
		rows[10] = mk({17'(rand_bits(17)), 3'b000, 5'd4, decode_pkg::OPC_SYSTEM}, 0, 0, 0, 0, 0, 0);
		rows[11] = mk(decode_pkg::INST_ECALL, 0, 0, 0, 0, 0, 0);
		rows[12] = mk(decode_pkg::INST_MRET, 0, 0, 0, 0, 1, 0);
		rows[13] = mk(32'h0000100f, 0, 0, 0, 0, 0, 0); // fence.i
		rows[14] = mk({25'(rand_bits(25)), 7'h7f}, 0, 0, 0, 0, 0, 0);
		rows[15] = mk(enc_r(4'd3, 4'd0, 4'd6), 0, 0, 0, 0, 0, 0);
		rows[16] = mk(enc_r(4'd2, 4'd1, 4'd5), 1, 1, 3, 0, 0, 1);
		rows[17] = mk(enc_i(12'h002, 4'd1, 4'd5, decode_pkg::OPC_ALU_IMM), 1, 2, 2, 0, 0, 0);
		rows[18] = mk(enc_r(4'd2, 4'd1, 4'd5), 1, 2, 2, 0, 0, 1);
		rows[19] = mk(enc_r(4'd0, 4'd0, 4'd5), 1, 0, 2, 0, 0, 0);
		rows[20] = mk({7'h00, 5'd6, 5'd1, 3'b000, 5'd0, decode_pkg::OPC_BRANCH}, 2, 6, 4, 0, 0, 1);
		rows[21] = mk({7'h00, 5'd3, 5'd2, 3'b010, 5'd0, decode_pkg::OPC_STORE}, 1, 3, 2, 0, 0, 1);
	endtask

	task automatic write_reg(input decode_pkg::reg_addr_t r, input decode_pkg::word_t d);
		@(posedge clock);
		#1;
		wb_en = 1'b1;
		wb_rd = r;
		wb_data = d;
		@(posedge clock);
		#1;
		wb_en = 1'b0;
	endtask

	task automatic wait_ready(output bit found);
		found = 0;
		for (int n = 0; n < 50 && !found; n++) begin
			@(negedge clock);
			found = in_ready;
		end
	endtask

	task automatic run_row(input row_t r);
		bit found;
		@(posedge clock);
		#1;
		inst = r.inst;
		pc = r.pc;
		in_valid = 1'b1;
		exu_rd = r.hz_rd;
		lsu_rd = r.hz_rd;
		exu_reg_wen = (r.hz == 1);
		exu_ready = (r.hz != 1);
		lsu_reg_wen = (r.hz == 2);
		lsu_ready = (r.hz != 2);
		found = 0;
		for (int n = 0; n < 50 && !found; n++) begin
			@(negedge clock);
			if (n == 0) u_checker.check("in_ready", in_ready, !r.stall);
			found = in_ready;
			if (!found && n + 1 >= r.busy) begin
				@(posedge clock);
				#1;
				exu_ready = 1'b1; // Busy stage finishes
				lsu_ready = 1'b1;
			end
		end
		if (!found) u_checker.note_failure("in_ready never rose for the instruction");
		@(posedge clock);
		#1;
		in_valid = 1'b0;
		exu_reg_wen = 1'b0;
		lsu_reg_wen = 1'b0;
		found = 0;
		for (int n = 0; n < 50 && !found; n++) begin
			@(negedge clock);
			found = out_valid;
		end
		if (!found) u_checker.note_failure("out_valid never rose after acceptance");
		repeat (r.hold) @(negedge clock); // Back-pressure while the outputs hold
		@(posedge clock);
		#1;
		if (r.flush) jump_wrong = 1'b1;
		else out_ready = 1'b1;
		@(posedge clock);
		#1;
		jump_wrong = 1'b0;
		out_ready = 1'b0;
		wait_ready(found);
		if (!found) u_checker.note_failure("in_ready did not return after the hand-off");
		u_checker.end_test();
	endtask

	initial begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		out_ready = 1'b0;
		inst = '0;
		pc = '0;
		exu_rd = '0;
		exu_reg_wen = 1'b0;
		exu_ready = 1'b1;
		lsu_rd = '0;
		lsu_reg_wen = 1'b0;
		lsu_ready = 1'b1;
		jump_wrong = 1'b0;
		wb_en = 1'b0;
		wb_rd = '0;
		wb_data = '0;
		build_table();
		repeat (3) @(posedge clock);
		#1;
		rst_n = 1'b1;
		repeat (2) @(negedge clock); // Idle state after reset
		u_checker.end_test();
		write_reg(4'd1, rand_bits(32));
		write_reg(4'd2, rand_bits(32));
		write_reg(4'd3, rand_bits(32));
		write_reg(4'd0, rand_bits(32));
		for (int i = 0; i < NUM_ROWS; i++) begin
			run_row(rows[i]);
		end
		u_checker.report();
		if (u_checker.fail_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* logic/decode_pkg.sv */
`default_nettype none

package decode_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0] reg_addr_t;

	localparam int NUM_REGS = 16; // RV32E register count
	localparam int OP_CLASS_COUNT = 10;
	localparam int FMT_COUNT = 6;

	// Bit positions in the one-hot class vector
	typedef enum logic [3:0] {
		CLS_LUI     = 4'd0,
		CLS_AUIPC   = 4'd1,
		CLS_JAL     = 4'd2,
		CLS_JALR    = 4'd3,
		CLS_BRANCH  = 4'd4,
		CLS_LOAD    = 4'd5,
		CLS_STORE   = 4'd6,
		CLS_ALU_IMM = 4'd7,
		CLS_ALU_REG = 4'd8,
		CLS_SYSTEM  = 4'd9
	} op_class_e;

	typedef enum logic [2:0] {
		FMT_R = 3'd0,
		FMT_I = 3'd1,
		FMT_S = 3'd2,
		FMT_B = 3'd3,
		FMT_U = 3'd4,
		FMT_J = 3'd5
	} inst_fmt_e;

	localparam logic [6:0] OPC_LUI      = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
	localparam logic [6:0] OPC_JAL      = 7'b1101111;
	localparam logic [6:0] OPC_JALR     = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
	localparam logic [6:0] OPC_LOAD     = 7'b0000011;
	localparam logic [6:0] OPC_STORE    = 7'b0100011;
	localparam logic [6:0] OPC_ALU_IMM  = 7'b0010011;
	localparam logic [6:0] OPC_ALU_REG  = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;
	localparam logic [6:0] OPC_MISC_MEM = 7'b0001111; // fence / fence.i

	// Whole-word encodings of the privileged instructions
	localparam word_t INST_ECALL = 32'h00000073;
	localparam word_t INST_MRET  = 32'h30200073;

endpackage

`default_nettype wire

/* logic/decode_stage.sv */
`default_nettype none

module decode_stage (
	input  logic                                  clock,
	input  logic                                  rst_n,
	input  logic                                  in_valid,
	output logic                                  in_ready,
	input  decode_pkg::word_t                     inst,
	input  decode_pkg::word_t                     pc,
	input  decode_pkg::word_t                     src1,
	input  decode_pkg::word_t                     src2,
	output decode_pkg::reg_addr_t                 rs1,
	output decode_pkg::reg_addr_t                 rs2,
	input  decode_pkg::reg_addr_t                 exu_rd,
	input  logic                                  exu_reg_wen,
	input  logic                                  exu_ready,
	input  decode_pkg::reg_addr_t                 lsu_rd,
	input  logic                                  lsu_reg_wen,
	input  logic                                  lsu_ready,
	input  logic                                  jump_wrong,
	input  logic                                  out_ready,
	output logic                                  out_valid,
	output logic [decode_pkg::OP_CLASS_COUNT-1:0] op_class,
	output logic [2:0]                            funct3,
	output logic [6:0]                            funct7,
	output decode_pkg::reg_addr_t                 rd,
	output decode_pkg::word_t                     imm,
	output decode_pkg::word_t                     pc_out,
	output decode_pkg::word_t                     src1_out,
	output decode_pkg::word_t                     src2_out,
	output logic                                  reg_wen,
	output logic                                  is_fencei,
	output logic                                  is_ecall,
	output logic                                  is_mret
);

	decoded_inst_if dec ();

	logic empty; // Holding register free
	logic raw_conflict;
	logic accept;
	logic transfer;

	inst_decoder u_inst_decoder (
		.inst (inst),
		.dec  (dec.decoder)
	);

	hazard_check u_hazard_check (
		.dec          (dec.hazard),
		.exu_rd       (exu_rd),
		.lsu_rd       (lsu_rd),
		.exu_reg_wen  (exu_reg_wen),
		.exu_ready    (exu_ready),
		.lsu_reg_wen  (lsu_reg_wen),
		.lsu_ready    (lsu_ready),
		.raw_conflict (raw_conflict)
	);

	assign in_ready = empty & ~raw_conflict;
	assign accept   = in_valid & in_ready;
	assign transfer = out_valid & out_ready;

	assign rs1 = dec.rs1;
	assign rs2 = dec.rs2;

	// Flush wins over everything else
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			empty     <= 1'b1;
			out_valid <= 1'b0;
		end else if (jump_wrong) begin
			empty     <= 1'b1;
			out_valid <= 1'b0;
		end else if (accept) begin
			empty     <= 1'b0;
			out_valid <= 1'b1;
		end else if (transfer) begin
			empty     <= 1'b1; // Refill one cycle after the hand-off
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			op_class  <= dec.op_class;
			funct3    <= dec.funct3;
			funct7    <= dec.funct7;
			rd        <= dec.rd;
			imm       <= dec.imm;
			reg_wen   <= dec.reg_wen;
			is_fencei <= dec.is_fencei;
			is_ecall  <= dec.is_ecall;
			is_mret   <= dec.is_mret;
			pc_out    <= pc;
			src1_out  <= src1;
			src2_out  <= src2;
		end
	end

endmodule

`default_nettype wire

/* logic/decode_top.sv */
`default_nettype none

module decode_top (
	input  logic                                  clock,
	input  logic                                  rst_n,
	input  logic                                  in_valid,
	output logic                                  in_ready,
	input  decode_pkg::word_t                     inst,
	input  decode_pkg::word_t                     pc,
	output logic                                  out_valid,
	input  logic                                  out_ready,
	output logic [decode_pkg::OP_CLASS_COUNT-1:0] op_class,
	output logic [2:0]                            funct3,
	output logic [6:0]                            funct7,
	output decode_pkg::reg_addr_t                 rd,
	output decode_pkg::word_t                     imm,
	output decode_pkg::word_t                     pc_out,
	output decode_pkg::word_t                     src1_out,
	output decode_pkg::word_t                     src2_out,
	output logic                                  reg_wen,
	output logic                                  is_fencei,
	output logic                                  is_ecall,
	output logic                                  is_mret,
	input  decode_pkg::reg_addr_t                 exu_rd,
	input  logic                                  exu_reg_wen,
	input  logic                                  exu_ready,
	input  decode_pkg::reg_addr_t                 lsu_rd,
	input  logic                                  lsu_reg_wen,
	input  logic                                  lsu_ready,
	input  logic                                  jump_wrong,
	input  logic                                  wb_en,
	input  decode_pkg::reg_addr_t                 wb_rd,
	input  decode_pkg::word_t                     wb_data
);

	decode_pkg::reg_addr_t rs1;
	decode_pkg::reg_addr_t rs2;
	decode_pkg::word_t src1;
	decode_pkg::word_t src2;

	register_file u_register_file (
		.clock   (clock),
		.rst_n   (rst_n),
		.wb_en   (wb_en),
		.wb_rd   (wb_rd),
		.rs1     (rs1),
		.rs2     (rs2),
		.wb_data (wb_data),
		.src1    (src1),
		.src2    (src2)
	);

	decode_stage u_decode_stage (
		.clock       (clock),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.inst        (inst),
		.pc          (pc),
		.src1        (src1),
		.src2        (src2),
		.rs1         (rs1),
		.rs2         (rs2),
		.exu_rd      (exu_rd),
		.exu_reg_wen (exu_reg_wen),
		.exu_ready   (exu_ready),
		.lsu_rd      (lsu_rd),
		.lsu_reg_wen (lsu_reg_wen),
		.lsu_ready   (lsu_ready),
		.jump_wrong  (jump_wrong),
		.out_ready   (out_ready),
		.out_valid   (out_valid),
		.op_class    (op_class),
		.funct3      (funct3),
		.funct7      (funct7),
		.rd          (rd),
		.imm         (imm),
		.pc_out      (pc_out),
		.src1_out    (src1_out),
		.src2_out    (src2_out),
		.reg_wen     (reg_wen),
		.is_fencei   (is_fencei),
		.is_ecall    (is_ecall),
		.is_mret     (is_mret)
	);

endmodule

`default_nettype wire

/* logic/decoded_inst_if.sv */
`default_nettype none

interface decoded_inst_if;

	logic [decode_pkg::OP_CLASS_COUNT-1:0] op_class; // One-hot, indexed by op_class_e
	logic [2:0] funct3;
	logic [6:0] funct7;
	decode_pkg::reg_addr_t rd;
	decode_pkg::reg_addr_t rs1;
	decode_pkg::reg_addr_t rs2;
	decode_pkg::word_t imm;
	logic reg_wen;
	logic need_rs2;
	logic is_fencei;
	logic is_ecall;
	logic is_mret;

	modport decoder (
		output op_class, funct3, funct7, rd, rs1, rs2, imm,
		output reg_wen, need_rs2, is_fencei, is_ecall, is_mret
	);

	modport stage (
		input op_class, funct3, funct7, rd, rs1, rs2, imm,
		input reg_wen, need_rs2, is_fencei, is_ecall, is_mret
	);

	// Only the source fields matter for the RAW check
	modport hazard (
		input rs1, rs2, need_rs2
	);

endinterface

`default_nettype wire

/* logic/hazard_check.sv */
`default_nettype none

module hazard_check (
	decoded_inst_if.hazard        dec,
	input  decode_pkg::reg_addr_t exu_rd,
	input  decode_pkg::reg_addr_t lsu_rd,
	input  logic                  exu_reg_wen,
	input  logic                  exu_ready,
	input  logic                  lsu_reg_wen,
	input  logic                  lsu_ready,
	output logic                  raw_conflict
);

	logic exu_conflict;
	logic lsu_conflict;

	// A busy stage that still owes a write to one of our sources
	function automatic logic stage_conflict(
		input decode_pkg::reg_addr_t rd,
		input logic wen,
		input logic ready,
		input decode_pkg::reg_addr_t rs1,
		input decode_pkg::reg_addr_t rs2,
		input logic need_rs2
	);
		logic match;
		match = (rd == rs1) | ((rd == rs2) & need_rs2);
		return ~ready & wen & (rd != '0) & match;
	endfunction

	assign exu_conflict = stage_conflict(exu_rd, exu_reg_wen, exu_ready,
		dec.rs1, dec.rs2, dec.need_rs2);
	assign lsu_conflict = stage_conflict(lsu_rd, lsu_reg_wen, lsu_ready,
		dec.rs1, dec.rs2, dec.need_rs2);

	assign raw_conflict = exu_conflict | lsu_conflict;

endmodule

`default_nettype wire

/* logic/inst_decoder.sv */
`default_nettype none

module inst_decoder (
	input  decode_pkg::word_t inst,
	decoded_inst_if.decoder   dec
);

	logic [6:0] opcode;
	logic [decode_pkg::OP_CLASS_COUNT-1:0] cls;
	logic [decode_pkg::FMT_COUNT-1:0] fmt;
	decode_pkg::word_t imm_i;
	decode_pkg::word_t imm_u;
	decode_pkg::word_t imm_s;
	decode_pkg::word_t imm_j;
	decode_pkg::word_t imm_b;

	assign opcode = inst[6:0];

	assign cls[decode_pkg::CLS_LUI]     = (opcode == decode_pkg::OPC_LUI);
	assign cls[decode_pkg::CLS_AUIPC]   = (opcode == decode_pkg::OPC_AUIPC);
	assign cls[decode_pkg::CLS_JAL]     = (opcode == decode_pkg::OPC_JAL);
	assign cls[decode_pkg::CLS_JALR]    = (opcode == decode_pkg::OPC_JALR);
	assign cls[decode_pkg::CLS_BRANCH]  = (opcode == decode_pkg::OPC_BRANCH);
	assign cls[decode_pkg::CLS_LOAD]    = (opcode == decode_pkg::OPC_LOAD);
	assign cls[decode_pkg::CLS_STORE]   = (opcode == decode_pkg::OPC_STORE);
	assign cls[decode_pkg::CLS_ALU_IMM] = (opcode == decode_pkg::OPC_ALU_IMM);
	assign cls[decode_pkg::CLS_ALU_REG] = (opcode == decode_pkg::OPC_ALU_REG);
	assign cls[decode_pkg::CLS_SYSTEM]  = (opcode == decode_pkg::OPC_SYSTEM);

	// Class to format
	assign fmt[decode_pkg::FMT_R] = cls[decode_pkg::CLS_ALU_REG];
	assign fmt[decode_pkg::FMT_I] = cls[decode_pkg::CLS_JALR] | cls[decode_pkg::CLS_LOAD]
		| cls[decode_pkg::CLS_ALU_IMM] | cls[decode_pkg::CLS_SYSTEM];
	assign fmt[decode_pkg::FMT_S] = cls[decode_pkg::CLS_STORE];
	assign fmt[decode_pkg::FMT_B] = cls[decode_pkg::CLS_BRANCH];
	assign fmt[decode_pkg::FMT_U] = cls[decode_pkg::CLS_LUI] | cls[decode_pkg::CLS_AUIPC];
	assign fmt[decode_pkg::FMT_J] = cls[decode_pkg::CLS_JAL];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
	assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

	always_comb begin
		if (fmt[decode_pkg::FMT_I]) begin
			dec.imm = imm_i;
		end else if (fmt[decode_pkg::FMT_U]) begin
			dec.imm = imm_u;
		end else if (fmt[decode_pkg::FMT_S]) begin
			dec.imm = imm_s;
		end else if (fmt[decode_pkg::FMT_J]) begin
			dec.imm = imm_j;
		end else if (fmt[decode_pkg::FMT_B]) begin
			dec.imm = imm_b;
		end else begin
			dec.imm = '0; // R format and unknown opcodes
		end
	end

	assign dec.op_class = cls;
	assign dec.funct3   = inst[14:12];
	assign dec.funct7   = inst[31:25];

	// RV32E has only x0..x15
	assign dec.rd  = inst[10:7];
	assign dec.rs1 = inst[18:15];
	assign dec.rs2 = inst[23:20];

	// CSR ops write rd, ecall/mret/ebreak (funct3 zero) do not
	assign dec.reg_wen = fmt[decode_pkg::FMT_R] | fmt[decode_pkg::FMT_U] | fmt[decode_pkg::FMT_J]
		| (fmt[decode_pkg::FMT_I] & ~(cls[decode_pkg::CLS_SYSTEM] & (inst[14:12] == 3'b000)));

	assign dec.need_rs2 = cls[decode_pkg::CLS_BRANCH] | cls[decode_pkg::CLS_STORE]
		| cls[decode_pkg::CLS_ALU_REG];

	assign dec.is_ecall  = (inst == decode_pkg::INST_ECALL);
	assign dec.is_mret   = (inst == decode_pkg::INST_MRET);
	assign dec.is_fencei = (opcode == decode_pkg::OPC_MISC_MEM);

endmodule

`default_nettype wire

/* logic/register_file.sv */
`default_nettype none

module register_file (
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  wb_en,
	input  decode_pkg::reg_addr_t wb_rd,
	input  decode_pkg::reg_addr_t rs1,
	input  decode_pkg::reg_addr_t rs2,
	input  decode_pkg::word_t     wb_data,
	output decode_pkg::word_t     src1,
	output decode_pkg::word_t     src2
);

	decode_pkg::word_t regs [decode_pkg::NUM_REGS];

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < decode_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en && (wb_rd != '0)) begin // x0 stays zero
			regs[wb_rd] <= wb_data;
		end
	end

	// Reads see the value before a same-cycle write
	assign src1 = regs[rs1];
	assign src2 = regs[rs2];

endmodule

`default_nettype wire

/* project.f */
logic/decode_pkg.sv
logic/decoded_inst_if.sv
logic/inst_decoder.sv
logic/hazard_check.sv
logic/register_file.sv
logic/decode_stage.sv
logic/decode_top.sv
bench/decode_checker.sv
bench/decode_tb.sv
